// ==== ext_mem_fsm_pkg.sv ====
// State and wait-counter opcode types for the external SRAM controller.
// Imported by the sequencer, the wait counter, the strobe generator and the top.

`default_nettype none

package ext_mem_fsm_pkg;

  // --------------------------------------------------
  // Sequencer states
  // --------------------------------------------------
  // Write states follow a one-bit-change order
  typedef enum logic [2:0] {
    IDLE     = 3'b000,
    WR_SETUP = 3'b001, // Address and data setup
    WR_PULSE = 3'b011, // we_n low
    WR_HOLD  = 3'b010, // Data hold, done
    READ     = 3'b100  // oe_n low
  } mem_state_e;

  // --------------------------------------------------
  // Wait counter operations
  // --------------------------------------------------
  typedef enum logic [2:0] {
    HOLD_ZERO  = 3'b000, // Clear count
    DECREMENT  = 3'b001,
    LOAD_READ  = 3'b010, // Load read cycle count
    LOAD_WRITE = 3'b011, // Load write pulse count
    LOAD_TURN  = 3'b100  // Load turnaround gap
  } count_op_e;

endpackage

`default_nettype wire

// ==== ext_mem_bus_pkg.sv ====
// SRAM bus definitions: byte lane count, request mask and lane strobe types.
// Imported where the byte mask or the byte strobes are handled.

`default_nettype none

package ext_mem_bus_pkg;

  // 16-bit SRAM, two byte lanes
  localparam int BYTE_LANES = 2;

  // Request side byte mask
  // Bit 0 lower byte, bit 1 upper byte
  // Active high, one bit per lane
  typedef logic [BYTE_LANES-1:0] byte_mask_t;

  // Pin side byte strobes
  // Same lane order as the mask but active low (lb_n, ub_n)
  typedef logic [BYTE_LANES-1:0] lane_strobe_n_t;

endpackage

`default_nettype wire

// ==== ext_mem_wait_counter.sv ====
// Wait-state counter for the SRAM controller.
// The sequencer selects an operation each cycle; count_zero ends each wait.

`timescale 1ns/1ps
`default_nettype none

module ext_mem_wait_counter
  import ext_mem_fsm_pkg::*;
#(
  parameter int CYCLE_W = 3 // Width of config counts
)
(
  input  logic               HCLK,
  input  logic               HRESETn,
  input  count_op_e          count_op,             // From sequencer
  input  logic [CYCLE_W-1:0] cfg_read_cycle,       // Read length minus one
  input  logic [CYCLE_W-1:0] cfg_write_cycle,      // Write pulse length minus one
  input  logic [CYCLE_W-1:0] cfg_turnaround_cycle, // Gap length minus one
  output logic               count_zero            // Wait finished
);

  logic [CYCLE_W-1:0] count;
  logic [CYCLE_W-1:0] nxt_count;

  // Next count from opcode
  always_comb
  begin
    case (count_op)
      DECREMENT:  nxt_count = count - 1'b1; // Never issued at zero
      LOAD_READ:  nxt_count = cfg_read_cycle;
      LOAD_WRITE: nxt_count = cfg_write_cycle;
      LOAD_TURN:  nxt_count = cfg_turnaround_cycle;
      default:    nxt_count = '0;            // HOLD_ZERO
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      count <= '0;
    else
      count <= nxt_count;
  end

  assign count_zero = (count == '0);

endmodule

`default_nettype wire

// ==== ext_mem_ctrl_fsm.sv ====
// Transfer sequencer for the SRAM controller.
// Steps through read, write and turnaround states from level requests,
// drives the wait counter and pulses done once per finished transfer.

`timescale 1ns/1ps
`default_nettype none

module ext_mem_ctrl_fsm
  import ext_mem_fsm_pkg::*;
(
  input  logic       HCLK,
  input  logic       HRESETn,
  input  logic       rd_req,     // Level, held until done
  input  logic       wr_req,     // Level, held until done
  input  logic       count_zero, // Current wait finished
  output count_op_e  count_op,   // To wait counter
  output mem_state_e nxt_state,  // To strobe generator
  output logic       done        // One cycle per transfer
);

  mem_state_e cur_state;
  logic       last_write; // 1 = last transfer was a write

  // --------------------------------------------------
  // Next state and counter operation
  // --------------------------------------------------
  always_comb
  begin
    nxt_state = cur_state;
    count_op  = HOLD_ZERO;
    case (cur_state)
      IDLE:
      begin
        if (rd_req)
        begin
          if (!count_zero && last_write)
            count_op = DECREMENT; // Turnaround after write
          else
          begin
            nxt_state = READ;
            count_op  = LOAD_READ;
          end
        end
        else if (wr_req)
        begin
          if (!count_zero && !last_write)
            count_op = DECREMENT; // Turnaround after read
          else
          begin
            nxt_state = WR_SETUP;
            count_op  = LOAD_WRITE;
          end
        end
        else if (!count_zero)
          count_op = DECREMENT;   // Let the gap run out
      end
      READ:
      begin
        if (!count_zero)
          count_op = DECREMENT;
        else if (rd_req)
          count_op = LOAD_READ;   // Chained read, no gap
        else
        begin
          nxt_state = IDLE;
          count_op  = LOAD_TURN;
        end
      end
      WR_SETUP:
      begin
        nxt_state = WR_PULSE;
        count_op  = LOAD_WRITE;   // Pulse length
      end
      WR_PULSE:
      begin
        if (!count_zero)
          count_op = DECREMENT;
        else
          nxt_state = WR_HOLD;
      end
      WR_HOLD:
      begin
        if (wr_req)
        begin
          nxt_state = WR_SETUP;   // Chained write
          count_op  = LOAD_WRITE;
        end
        else
        begin
          nxt_state = IDLE;
          count_op  = LOAD_TURN;
        end
      end
      default:
        nxt_state = IDLE;         // Recover from bad encoding
    endcase
  end

  // End of read wait or write hold
  assign done = ((cur_state == READ) && count_zero) || (cur_state == WR_HOLD);

  // --------------------------------------------------
  // State and direction registers
  // --------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      cur_state  <= IDLE;
      last_write <= 1'b0; // Read after reset
    end
    else
    begin
      cur_state <= nxt_state;
      if (done)
        last_write <= (cur_state == WR_HOLD);
    end
  end

endmodule

`default_nettype wire

// ==== ext_mem_strobe_gen.sv ====
// SRAM strobe generator.
// Decodes the sequencer's next state and the byte mask into active-low
// strobes, registered so the pins change on the state edge without glitches.

`timescale 1ns/1ps
`default_nettype none

module ext_mem_strobe_gen
  import ext_mem_fsm_pkg::*;
  import ext_mem_bus_pkg::*;
(
  input  logic       HCLK,
  input  logic       HRESETn,
  input  mem_state_e nxt_state,     // From sequencer
  input  byte_mask_t nxt_byte_mask, // Sampled on state entry
  output logic       ce_n,          // Chip enable
  output logic       oe_n,          // Output enable, read
  output logic       we_n,          // Write enable
  output logic       data_oe_n,     // Data bus drive, write
  output logic       lb_n,          // Lower byte
  output logic       ub_n           // Upper byte
);

  logic           nxt_ce_n;
  logic           nxt_oe_n;
  logic           nxt_we_n;
  logic           nxt_data_oe_n;
  lane_strobe_n_t nxt_bs_n;
  lane_strobe_n_t bs_n;

  // --------------------------------------------------
  // State decode
  // --------------------------------------------------
  always_comb
  begin
    nxt_ce_n      = 1'b0;
    nxt_oe_n      = 1'b1;
    nxt_we_n      = 1'b1;
    nxt_data_oe_n = 1'b1;
    nxt_bs_n      = ~nxt_byte_mask;
    case (nxt_state)
      READ:               nxt_oe_n      = 1'b0;
      WR_SETUP, WR_HOLD:  nxt_data_oe_n = 1'b0; // Data driven, no pulse
      WR_PULSE:
      begin
        nxt_data_oe_n = 1'b0;
        nxt_we_n      = 1'b0;
      end
      default:
      begin
        nxt_ce_n = 1'b1;  // IDLE, all off
        nxt_bs_n = '1;
      end
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      ce_n      <= 1'b1;
      oe_n      <= 1'b1;
      we_n      <= 1'b1;
      data_oe_n <= 1'b1;
      bs_n      <= '1;
    end
    else
    begin
      ce_n      <= nxt_ce_n;
      oe_n      <= nxt_oe_n;
      we_n      <= nxt_we_n;
      data_oe_n <= nxt_data_oe_n;
      bs_n      <= nxt_bs_n;
    end
  end

  assign lb_n = bs_n[0];
  assign ub_n = bs_n[1];

endmodule

`default_nettype wire

// ==== ext_mem_if.sv ====
// Top level of the external 16-bit SRAM controller.
// Requests are levels answered by a one-cycle done; the SRAM strobes come
// straight from registers. CYCLE_W sets the width of the config counts.

`timescale 1ns/1ps
`default_nettype none

module ext_mem_if
  import ext_mem_fsm_pkg::*;
  import ext_mem_bus_pkg::*;
#(
  parameter int CYCLE_W = 3
)
(
  input  logic               HCLK,
  input  logic               HRESETn,

  // Requester side
  input  logic               rd_req,
  input  logic               wr_req,
  input  byte_mask_t         nxt_byte_mask,
  output logic               done,

  // Static while a transfer is active
  input  logic [CYCLE_W-1:0] cfg_read_cycle,
  input  logic [CYCLE_W-1:0] cfg_write_cycle,
  input  logic [CYCLE_W-1:0] cfg_turnaround_cycle,

  // SRAM pins, all active low
  output logic               ce_n,
  output logic               oe_n,
  output logic               we_n,
  output logic               data_oe_n,
  output logic               lb_n,
  output logic               ub_n
);

  count_op_e  count_op;
  logic       count_zero;
  mem_state_e nxt_state;

  // --------------------------------------------------
  // Wait counter
  // --------------------------------------------------
  ext_mem_wait_counter #(
    .CYCLE_W (CYCLE_W)
  ) u_wait_counter (
    .HCLK                 (HCLK),
    .HRESETn              (HRESETn),
    .count_op             (count_op),
    .cfg_read_cycle       (cfg_read_cycle),
    .cfg_write_cycle      (cfg_write_cycle),
    .cfg_turnaround_cycle (cfg_turnaround_cycle),
    .count_zero           (count_zero)
  );

  // Sequencer
  ext_mem_ctrl_fsm u_ctrl_fsm (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .rd_req     (rd_req),
    .wr_req     (wr_req),
    .count_zero (count_zero),
    .count_op   (count_op),
    .nxt_state  (nxt_state),
    .done       (done)
  );

  // Pin strobes, registered
  ext_mem_strobe_gen u_strobe_gen (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .nxt_state     (nxt_state),
    .nxt_byte_mask (nxt_byte_mask),
    .ce_n          (ce_n),
    .oe_n          (oe_n),
    .we_n          (we_n),
    .data_oe_n     (data_oe_n),
    .lb_n          (lb_n),
    .ub_n          (ub_n)
  );

endmodule

`default_nettype wire

// ==== tb_ext_mem_if.sv ====
// Self-checking testbench for the external SRAM controller.
// Random configurations, masks and request mixes drive the DUT while
// concurrent assertions on the DUT pins check the strobe waveforms.

`timescale 1ns/1ps
`default_nettype none

module tb_ext_mem_if
  import ext_mem_bus_pkg::*;
;

  localparam int CYCLE_W = 3;
  localparam int ROUNDS  = 12;
  localparam int OPS     = 10;  // Request groups per round
  localparam int TIMEOUT = 200; // Cycles per done wait

  logic               HCLK = 1'b0;
  logic               HRESETn;
  logic               rd_req;
  logic               wr_req;
  byte_mask_t         nxt_byte_mask;
  logic               done;
  logic [CYCLE_W-1:0] cfg_read_cycle;
  logic [CYCLE_W-1:0] cfg_write_cycle;
  logic [CYCLE_W-1:0] cfg_turnaround_cycle;
  logic               ce_n;
  logic               oe_n;
  logic               we_n;
  logic               data_oe_n;
  logic               lb_n;
  logic               ub_n;

  int   rd_seg         = 0;    // oe_n low cycles since last done
  int   we_run         = 0;    // we_n low cycles so far
  int   gap_run        = 0;    // Cycles with oe_n and data_oe_n both high
  logic last_was_write = 1'b0; // Direction of last active cycle
  int   errors         = 0;
  int   timeouts       = 0;
  int   transfers      = 0;

  always #20 HCLK = ~HCLK; // 40 ns period

  ext_mem_if #(.CYCLE_W(CYCLE_W)) DUT (.*);

  // --------------------------------------------------
  // Pin monitors sampled where outputs are stable
  // --------------------------------------------------
  always @(negedge HCLK)
  begin
    rd_seg  <= (oe_n || done) ? 0 : rd_seg + 1;
    we_run  <= we_n ? 0 : we_run + 1;
    gap_run <= (oe_n && data_oe_n) ? gap_run + 1 : 0;
    if (!data_oe_n)
      last_was_write <= 1'b1;
    else if (!oe_n)
      last_was_write <= 1'b0;
  end

  task automatic report_mismatch(input string what, input int got, input int expected);
    errors++;
    $display("Fail %s: got %h expected %h", what, got, expected);
  endtask

  task automatic report_violation(input string what);
    errors++;
    $display("Error at %0t ns: %s", $time, what);
  endtask

  // --------------------------------------------------
  // Waveform assertions
  // --------------------------------------------------
  // Reset and idle
  assert property (@(negedge HCLK) !HRESETn
    |-> (ce_n && oe_n && we_n && data_oe_n && lb_n && ub_n && !done))
    else report_violation("strobes not all high or done set during reset");
  assert property (@(negedge HCLK) disable iff (!HRESETn)
    (!rd_req && !wr_req && $past(!rd_req && !wr_req))
    |-> (ce_n && oe_n && we_n && data_oe_n && lb_n && ub_n && !done))
    else report_violation("strobes not all high or done set while idle");

  // Read width and done in the last cycle only
  assert property (@(negedge HCLK) disable iff (!HRESETn)
    (!oe_n && done) |-> rd_seg == int'(cfg_read_cycle))
    else report_mismatch("oe_n low cycles at done", $sampled(rd_seg) + 1,
                         int'($sampled(cfg_read_cycle)) + 1);
  assert property (@(negedge HCLK) disable iff (!HRESETn)
    (!oe_n && !done) |-> rd_seg < int'(cfg_read_cycle))
    else report_violation("read ran past its configured length without done");
  assert property (@(negedge HCLK) disable iff (!HRESETn)
    $past(!oe_n && done) |-> (oe_n == !rd_req))
    else report_mismatch("oe_n after read done", $sampled(oe_n), !$sampled(rd_req));

  // Write waveform
  assert property (@(negedge HCLK) disable iff (!HRESETn)
    $past(!data_oe_n && we_n && !done) |-> !we_n)
    else report_mismatch("we_n after setup cycle", $sampled(we_n), 0);
  assert property (@(negedge HCLK) disable iff (!HRESETn)
    $fell(we_n) |-> $past(!data_oe_n && we_n && !done))
    else report_violation("we_n fell without one setup cycle of data_oe_n");
  assert property (@(negedge HCLK) disable iff (!HRESETn)
    $rose(we_n) |-> we_run == int'(cfg_write_cycle) + 1)
    else report_mismatch("we_n low cycles", $sampled(we_run),
                         int'($sampled(cfg_write_cycle)) + 1);
  assert property (@(negedge HCLK) disable iff (!HRESETn)
    $rose(we_n) |-> (!data_oe_n && done))
    else report_violation("hold cycle lacks data_oe_n low or done");
  assert property (@(negedge HCLK) disable iff (!HRESETn)
    !we_n |-> (!data_oe_n && !(lb_n && ub_n)))
    else report_violation("we_n low without data drive or byte lane");

  // Turnaround between directions
  assert property (@(negedge HCLK) disable iff (!HRESETn)
    (($fell(oe_n) && last_was_write) || ($fell(data_oe_n) && !last_was_write))
    |-> gap_run > int'(cfg_turnaround_cycle))
    else report_mismatch("turnaround gap cycles", $sampled(gap_run),
                         int'($sampled(cfg_turnaround_cycle)) + 1);

  // Bus safety and byte lanes
  assert property (@(negedge HCLK) disable iff (!HRESETn)
    (!oe_n || !data_oe_n) |-> (!ce_n && (oe_n || data_oe_n)))
    else report_violation("bus contention or ce_n high while enabled");
  assert property (@(negedge HCLK) disable iff (!HRESETn)
    !ce_n |-> {ub_n, lb_n} == ~nxt_byte_mask)
    else report_mismatch("{ub_n,lb_n}", $sampled({ub_n, lb_n}), $sampled(~nxt_byte_mask));

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic finish_run;
    $display("Run complete: %0d transfers, %0d errors, %0d timeouts",
             transfers, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  endtask

  // Waits on falling edges until done
  task automatic wait_done;
    int cycles;
    cycles = 0;
    do
    begin
      @(negedge HCLK);
      cycles++;
    end
    while (!done && cycles < TIMEOUT);
    if (done)
      transfers++;
    else
    begin
      timeouts++;
      $display("Timeout: no done within %0d cycles of the request", TIMEOUT);
    end
  endtask

  // Same-direction group; hold keeps the request up for a chain or a turn
  task automatic run_transfers(input logic is_write, input int count, input logic hold);
    int i;
    for (i = 0; i < count && timeouts == 0; i++)
    begin
      nxt_byte_mask = byte_mask_t'($urandom_range(1, 3)); // Never empty
      rd_req        = !is_write;
      wr_req        = is_write;
      wait_done();
    end
    if (!hold)
    begin
      rd_req = 1'b0;
      wr_req = 1'b0;
      repeat ($urandom_range(1, 4)) @(negedge HCLK);
    end
  endtask

  initial
  begin
    int round;
    int op;
    HRESETn              = 1'b0;
    rd_req               = 1'b0;
    wr_req               = 1'b0;
    nxt_byte_mask        = '0;
    cfg_read_cycle       = '0;
    cfg_write_cycle      = '0;
    cfg_turnaround_cycle = '0;
    void'($urandom(32'h95f7_19d0));
    repeat (16) @(negedge HCLK);
    HRESETn = 1'b1;
    repeat (4) @(negedge HCLK); // Idle after reset
    for (round = 0; round < ROUNDS && timeouts == 0; round++)
    begin
      cfg_read_cycle       = CYCLE_W'($urandom);
      cfg_write_cycle      = CYCLE_W'($urandom);
      cfg_turnaround_cycle = CYCLE_W'($urandom);
      for (op = 0; op < OPS && timeouts == 0; op++)
        run_transfers(1'($urandom_range(0, 1)), $urandom_range(1, 3),
                      1'($urandom_range(0, 1)));
      rd_req = 1'b0;
      wr_req = 1'b0;
      repeat ((1 << CYCLE_W) + 2) @(negedge HCLK); // Gap runs out before new config
    end
    finish_run();
  end

endmodule

`default_nettype wire

// ==== project.f ====
ext_mem_fsm_pkg.sv
ext_mem_bus_pkg.sv
ext_mem_wait_counter.sv
ext_mem_ctrl_fsm.sv
ext_mem_strobe_gen.sv
ext_mem_if.sv
tb_ext_mem_if.sv

// ==== Makefile ====
# Verilator lint and simulation for the SRAM controller

VERILATOR ?= verilator
FILELIST  ?= project.f
TOP       ?= tb_ext_mem_if
RTL_TOP   ?= ext_mem_if
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG) || (echo "No result in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
